// File: verilog/dbus_pkg.sv
package dbus_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int RESP_W = 2;

	// One captured CPU request, 70 bits
	typedef struct packed {
		logic              read;
		logic              write;
		logic [ADDR_W-1:0] address;
		logic [DATA_W-1:0] wrdata;
		logic [STRB_W-1:0] byteenable;
	} dbus_req_t;

	// Bridge sequencing
	typedef enum logic [2:0] {
		IDLE,
		AR_WAIT,    // arvalid up, waiting for arready
		R_WAIT,     // rready up, waiting for rvalid
		AW_WAIT,
		W_WAIT,
		B_WAIT,     // CPU released, response still outstanding
		B_WAIT_REQ  // next request held until B arrives
	} bridge_state_t;

	// AXI response codes
	localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

	// Read data on a failed or timed out access
	localparam logic [DATA_W-1:0] BUS_ERR_DATA = 32'hdeadbeef;

endpackage

// File: verilog/cpu_dbus_if.sv
interface cpu_dbus_if;

	// Request from the CPU
	logic                        read;
	logic                        write;
	logic [dbus_pkg::ADDR_W-1:0] address;
	logic [dbus_pkg::DATA_W-1:0] wrdata;
	logic [dbus_pkg::STRB_W-1:0] byteenable;

	// Response back to the CPU
	logic [dbus_pkg::DATA_W-1:0] rddata;
	logic                        stall;
	logic                        error; // One cycle pulse

	modport cpu (
		output read, write, address, wrdata, byteenable,
		input  rddata, stall, error
	);

	modport bridge (
		input  read, write, address, wrdata, byteenable,
		output rddata, stall, error
	);

endinterface

// File: verilog/bridge_ctl_if.sv
interface bridge_ctl_if;

	// From the FSM
	logic capture_en; // Request register may load
	logic rd_done;    // R handshake this cycle
	logic abort;      // Watchdog fired in a wait state
	logic busy_next;  // Next state stalls the CPU
	logic err_b;      // B came back with SLVERR

	// Request visible to the FSM this cycle
	logic pend_read;
	logic pend_write;

	modport fsm (
		output capture_en, rd_done, abort, busy_next, err_b,
		input  pend_read, pend_write
	);

	modport stage (
		input  capture_en, rd_done, abort, busy_next, err_b,
		output pend_read, pend_write
	);

endinterface

// File: verilog/axi_watchdog.sv
module axi_watchdog #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic clear,
	output logic timeout
);

	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(TIMEOUT_CYCLES - 1);

	logic [CNT_W-1:0] count;

	// Fires on the last waiting cycle, never together with a handshake
	assign timeout = run && !clear && (count == LAST);

	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (!run || clear || timeout)
			count <= '0; // Restart for the next wait
		else
			count <= count + 1'b1;
	end

endmodule

// File: verilog/req_stage.sv
module req_stage (
	input  logic clk,
	input  logic rst,

	cpu_dbus_if.bridge bus,
	bridge_ctl_if.stage ctl,

	// AXI payload
	output logic [dbus_pkg::ADDR_W-1:0] araddr,
	output logic [dbus_pkg::ADDR_W-1:0] awaddr,
	output logic [dbus_pkg::DATA_W-1:0] wdata,
	output logic [dbus_pkg::STRB_W-1:0] wstrb
);

	dbus_pkg::dbus_req_t cpu_req;
	dbus_pkg::dbus_req_t req;

	assign cpu_req.read       = bus.read;
	assign cpu_req.write      = bus.write;
	assign cpu_req.address    = bus.address;
	assign cpu_req.wrdata     = bus.wrdata;
	assign cpu_req.byteenable = bus.byteenable;

	always_ff @(posedge clk) begin
		if (rst) begin
			req.read  <= 1'b0;
			req.write <= 1'b0;
		end else if (ctl.capture_en) begin
			req <= cpu_req;
		end else if (ctl.abort || ctl.rd_done) begin
			req.read  <= 1'b0; // Request finished
			req.write <= 1'b0;
		end
	end

	// Live request while loading, held one otherwise
	assign ctl.pend_read  = ctl.capture_en ? bus.read  : req.read;
	assign ctl.pend_write = ctl.capture_en ? bus.write : req.write;

	// Payload stays stable while valid is up
	assign araddr = req.address;
	assign awaddr = req.address;
	assign wdata  = req.wrdata;
	assign wstrb  = req.byteenable;

endmodule

// File: verilog/resp_stage.sv
module resp_stage (
	input  logic clk,
	input  logic rst,

	cpu_dbus_if.bridge bus,
	bridge_ctl_if.stage ctl,

	// AXI read data channel
	input  logic [dbus_pkg::DATA_W-1:0] rdata,
	input  logic [dbus_pkg::RESP_W-1:0] rresp
);

	logic                        r_err;
	logic                        stall_q;
	logic                        error_q;
	logic [dbus_pkg::DATA_W-1:0] rddata_q;

	assign r_err = ctl.rd_done && (rresp == dbus_pkg::RESP_SLVERR);

	always_ff @(posedge clk) begin
		if (rst) begin
			stall_q <= 1'b0;
			error_q <= 1'b0;
		end else begin
			stall_q <= ctl.busy_next;
			error_q <= r_err || ctl.err_b || ctl.abort; // Single cycle pulse
		end
	end

	// Read word lands together with the release of the stall
	always_ff @(posedge clk) begin
		if (ctl.rd_done)
			rddata_q <= r_err ? dbus_pkg::BUS_ERR_DATA : rdata;
		else if (ctl.abort)
			rddata_q <= dbus_pkg::BUS_ERR_DATA;
	end

	assign bus.stall  = stall_q;
	assign bus.error  = error_q;
	assign bus.rddata = rddata_q;

endmodule

// File: verilog/uncached_fsm.sv
module uncached_fsm (
	input  logic clk,
	input  logic rst,

	// AXI4-Lite handshakes
	input  logic                        arready,
	input  logic                        awready,
	input  logic                        wready,
	input  logic                        rvalid,
	input  logic                        bvalid,
	input  logic [dbus_pkg::RESP_W-1:0] bresp,
	output logic                        arvalid,
	output logic                        awvalid,
	output logic                        wvalid,
	output logic                        rready,
	output logic                        bready,

	bridge_ctl_if.fsm ctl,

	// Watchdog
	output logic wd_run,
	output logic wd_clear,
	input  logic timeout
);

	dbus_pkg::bridge_state_t state, state_d;

	logic b_phase;
	logic b_done;
	logic ar_hs;
	logic aw_hs;
	logic w_hs;

	// Where a pending request starts its address phase
	function automatic dbus_pkg::bridge_state_t issue_state(input logic rd, input logic wr);
		if (rd)
			return dbus_pkg::AR_WAIT;
		else if (wr)
			return dbus_pkg::AW_WAIT;
		return dbus_pkg::IDLE;
	endfunction

	assign b_phase = (state == dbus_pkg::B_WAIT) || (state == dbus_pkg::B_WAIT_REQ);

	// A timed out B counts as finished so a held request is not lost
	assign b_done = b_phase && (bvalid || ctl.abort);

	assign ar_hs = arvalid && arready;
	assign aw_hs = awvalid && awready;
	assign w_hs  = wvalid && wready;

	always_comb begin
		state_d = state;
		case (state)
			dbus_pkg::IDLE:
				state_d = issue_state(ctl.pend_read, ctl.pend_write);
			dbus_pkg::AR_WAIT:
				if (arready) state_d = dbus_pkg::R_WAIT;
			dbus_pkg::R_WAIT:
				if (rvalid) state_d = dbus_pkg::IDLE;
			dbus_pkg::AW_WAIT:
				if (awready) state_d = dbus_pkg::W_WAIT;
			dbus_pkg::W_WAIT:
				if (wready) state_d = dbus_pkg::B_WAIT;
			dbus_pkg::B_WAIT: begin
				if (b_done)
					state_d = issue_state(ctl.pend_read, ctl.pend_write);
				else if (ctl.pend_read || ctl.pend_write)
					state_d = dbus_pkg::B_WAIT_REQ;
			end
			dbus_pkg::B_WAIT_REQ:
				if (b_done) state_d = issue_state(ctl.pend_read, ctl.pend_write);
			default:
				state_d = dbus_pkg::IDLE;
		endcase

		if (ctl.abort && !b_phase)
			state_d = dbus_pkg::IDLE;
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= dbus_pkg::IDLE;
		else
			state <= state_d;
	end

	// Channel valids come straight from the state
	assign arvalid = (state == dbus_pkg::AR_WAIT);
	assign awvalid = (state == dbus_pkg::AW_WAIT);
	assign wvalid  = (state == dbus_pkg::W_WAIT);
	assign rready  = (state == dbus_pkg::R_WAIT);
	assign bready  = 1'b1;

	// Requests are taken only while the CPU is not stalled
	assign ctl.capture_en = (state == dbus_pkg::IDLE) || (state == dbus_pkg::B_WAIT);
	assign ctl.busy_next  = (state_d != dbus_pkg::IDLE) && (state_d != dbus_pkg::B_WAIT);
	assign ctl.rd_done    = rvalid && rready;
	assign ctl.abort      = timeout && wd_run;
	assign ctl.err_b      = b_phase && bvalid && (bresp == dbus_pkg::RESP_SLVERR);

	assign wd_run   = (state != dbus_pkg::IDLE);
	assign wd_clear = ar_hs || aw_hs || w_hs || ctl.rd_done || (b_phase && bvalid);

endmodule

// File: verilog/uncached_dbus_top.sv
module uncached_dbus_top #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  logic clk,
	input  logic rst,

	// CPU data bus
	input  logic                        read,
	input  logic                        write,
	input  logic [dbus_pkg::ADDR_W-1:0] address,
	input  logic [dbus_pkg::DATA_W-1:0] wrdata,
	input  logic [dbus_pkg::STRB_W-1:0] byteenable,
	output logic [dbus_pkg::DATA_W-1:0] rddata,
	output logic                        stall,
	output logic                        error,

	// AXI4-Lite master
	output logic [dbus_pkg::ADDR_W-1:0] awaddr,
	output logic                        awvalid,
	input  logic                        awready,
	output logic [dbus_pkg::DATA_W-1:0] wdata,
	output logic [dbus_pkg::STRB_W-1:0] wstrb,
	output logic                        wvalid,
	input  logic                        wready,
	input  logic [dbus_pkg::RESP_W-1:0] bresp,
	input  logic                        bvalid,
	output logic                        bready,
	output logic [dbus_pkg::ADDR_W-1:0] araddr,
	output logic                        arvalid,
	input  logic                        arready,
	input  logic [dbus_pkg::DATA_W-1:0] rdata,
	input  logic [dbus_pkg::RESP_W-1:0] rresp,
	input  logic                        rvalid,
	output logic                        rready
);

	cpu_dbus_if   bus ();
	bridge_ctl_if ctl ();

	logic wd_run;
	logic wd_clear;
	logic timeout;

	assign bus.read       = read;
	assign bus.write      = write;
	assign bus.address    = address;
	assign bus.wrdata     = wrdata;
	assign bus.byteenable = byteenable;
	assign rddata         = bus.rddata;
	assign stall          = bus.stall;
	assign error          = bus.error;

	uncached_fsm u_fsm (
		.clk      (clk),
		.rst      (rst),
		.arready  (arready),
		.awready  (awready),
		.wready   (wready),
		.rvalid   (rvalid),
		.bvalid   (bvalid),
		.bresp    (bresp),
		.arvalid  (arvalid),
		.awvalid  (awvalid),
		.wvalid   (wvalid),
		.rready   (rready),
		.bready   (bready),
		.ctl      (ctl.fsm),
		.wd_run   (wd_run),
		.wd_clear (wd_clear),
		.timeout  (timeout)
	);

	req_stage u_req_stage (
		.clk    (clk),
		.rst    (rst),
		.bus    (bus.bridge),
		.ctl    (ctl.stage),
		.araddr (araddr),
		.awaddr (awaddr),
		.wdata  (wdata),
		.wstrb  (wstrb)
	);

	resp_stage u_resp_stage (
		.clk   (clk),
		.rst   (rst),
		.bus   (bus.bridge),
		.ctl   (ctl.stage),
		.rdata (rdata),
		.rresp (rresp)
	);

	axi_watchdog #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_watchdog (
		.clk     (clk),
		.rst     (rst),
		.run     (wd_run),
		.clear   (wd_clear),
		.timeout (timeout)
	);

endmodule

// File: test/axi_lite_slave_model.sv
module axi_lite_slave_model #(
	parameter logic [31:0] ERR_BASE  = 32'h1000,
	parameter logic [31:0] HANG_ADDR = 32'h2000
) (
	input  logic        clk,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] mem [logic [29:0]];
	logic [31:0] wr_lfsr, rd_lfsr;

	function automatic logic [31:0] fill(input logic [29:0] w);
		return {2'b00, w} ^ {w[13:0], w[29:14]} ^ 32'h6b3c_91e5;
	endfunction

	function automatic logic err_addr(input logic [31:0] a);
		return (a >= ERR_BASE) && (a < ERR_BASE + 32'h100);
	endfunction

	task automatic delay(inout logic [31:0] s);
		int n;
		n = 0;
		repeat (2) begin
			s = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
			n = n * 2 + s[0];
		end
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	initial begin
		logic [31:0] a, old;
		awready = 0;
		wready = 0;
		bvalid = 0;
		bresp = 2'b00;
		wr_lfsr = 32'h3a52;
		forever begin
			@(posedge clk);
			#2;
			if (awvalid === 1'b1 && awaddr != HANG_ADDR) begin // Hang address never answered
				delay(wr_lfsr);
				a = awaddr;
				awready = 1;
				@(posedge clk);
				#2;
				awready = 0;
				while (wvalid !== 1'b1) begin
					@(posedge clk);
					#2;
				end
				delay(wr_lfsr);
				wready = 1;
				old = mem.exists(a[31:2]) ? mem[a[31:2]] : fill(a[31:2]);
				for (int i = 0; i < 4; i++)
					if (wstrb[i])
						old[i*8 +: 8] = wdata[i*8 +: 8];
				if (!err_addr(a))
					mem[a[31:2]] = old;
				@(posedge clk);
				#2;
				wready = 0;
				delay(wr_lfsr);
				bvalid = 1;
				bresp = err_addr(a) ? 2'b10 : 2'b00;
				while (bready !== 1'b1) begin
					@(posedge clk);
					#2;
				end
				@(posedge clk);
				#2;
				bvalid = 0;
			end
		end
	end

	initial begin
		logic [31:0] a;
		arready = 0;
		rvalid = 0;
		rresp = 2'b00;
		rdata = '0;
		rd_lfsr = 32'h3a52;
		forever begin
			@(posedge clk);
			#2;
			if (arvalid === 1'b1 && araddr != HANG_ADDR) begin
				delay(rd_lfsr);
				a = araddr;
				arready = 1;
				@(posedge clk);
				#2;
				arready = 0;
				delay(rd_lfsr);
				rvalid = 1;
				rresp = err_addr(a) ? 2'b10 : 2'b00;
				rdata = mem.exists(a[31:2]) ? mem[a[31:2]] : fill(a[31:2]);
				while (rready !== 1'b1) begin
					@(posedge clk);
					#2;
				end
				@(posedge clk);
				#2;
				rvalid = 0;
			end
		end
	end

endmodule

// File: test/dbus_checker.sv
module dbus_checker #(
	parameter logic [31:0] ERR_BASE  = 32'h1000,
	parameter logic [31:0] HANG_ADDR = 32'h2000
) (
	input logic        clk,
	input logic        rst,
	input logic        read,
	input logic        write,
	input logic [31:0] address,
	input logic [31:0] wrdata,
	input logic [3:0]  byteenable,
	input logic [31:0] rddata,
	input logic        stall,
	input logic        error,
	input logic        awvalid, awready, wvalid, wready, bvalid,
	input logic        arvalid, rvalid, rready
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] ref_mem [logic [29:0]];
	logic        rst_d, busy, cur_read, r_seen, w_seen;
	logic [31:0] cur_addr, cur_data;
	logic [3:0]  cur_be;
	int          aw_cnt, b_cnt, pulses, exp_pulses;
	int          checks, errors, total_checks, total_errors, tests;

	function automatic logic [31:0] fill(input logic [29:0] w);
		return {2'b00, w} ^ {w[13:0], w[29:14]} ^ 32'h6b3c_91e5;
	endfunction

	function automatic logic bad_addr(input logic [31:0] a);
		return (a == HANG_ADDR) || ((a >= ERR_BASE) && (a < ERR_BASE + 32'h100));
	endfunction

	// Expected read word from all earlier stored writes
	function automatic logic [31:0] expected_read(input logic [31:0] a);
		if (bad_addr(a))
			return 32'hdeadbeef;
		return ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : fill(a[31:2]);
	endfunction

	task automatic fail(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic complete();
		logic [31:0] v;
		checks++;
		if (cur_read) begin
			if (cur_addr != HANG_ADDR && !r_seen)
				fail($sformatf("stall dropped at %0t before the R handshake", $time));
			if (rddata !== expected_read(cur_addr))
				fail($sformatf("mismatch at %0t: read 0x%h gave 0x%h, expected 0x%h",
					$time, cur_addr, rddata, expected_read(cur_addr)));
			if (error !== bad_addr(cur_addr))
				fail($sformatf("mismatch at %0t: error %b on read 0x%h", $time, error,
					cur_addr));
		end else begin
			if (cur_addr != HANG_ADDR && !w_seen)
				fail($sformatf("stall dropped at %0t before the W handshake", $time));
			if (!bad_addr(cur_addr)) begin
				v = expected_read(cur_addr);
				for (int i = 0; i < 4; i++)
					if (cur_be[i])
						v[i*8 +: 8] = cur_data[i*8 +: 8];
				ref_mem[cur_addr[31:2]] = v;
			end
		end
	endtask

	initial begin
		busy = 0;
		rst_d = 1;
		aw_cnt = 0;
		b_cnt = 0;
		pulses = 0;
		exp_pulses = 0;
		checks = 0;
		errors = 0;
		total_checks = 0;
		total_errors = 0;
		tests = 0;
	end

	always @(negedge clk) begin
		if (rst || rst_d) begin
			checks++;
			if (arvalid !== 0 || awvalid !== 0 || wvalid !== 0 || rready !== 0 ||
					stall !== 0 || error !== 0)
				fail($sformatf("mismatch at %0t: outputs not idle around reset", $time));
		end
		rst_d <= rst;
		if (!rst) begin
			if (arvalid && aw_cnt != b_cnt)
				fail($sformatf("read address issued at %0t with B outstanding", $time));
			if (rvalid && rready) r_seen = 1;
			if (wvalid && wready) w_seen = 1;
			if (awvalid && awready) aw_cnt++;
			if (bvalid) b_cnt++;
			if (error) pulses++;
			if (busy && !stall) begin
				complete();
				busy = 0;
			end
			if (!stall && (read || write)) begin // Taken at the next edge
				busy = 1;
				cur_read = read;
				cur_addr = address;
				cur_data = wrdata;
				cur_be = byteenable;
				r_seen = 0;
				w_seen = 0;
				if (bad_addr(address)) exp_pulses++;
			end
		end
	end

	task automatic end_test(input string name);
		while (aw_cnt != b_cnt || busy)
			@(posedge clk);
		repeat (2) @(posedge clk); // B error pulse lands one cycle after bvalid
		#2;
		checks++;
		if (pulses != exp_pulses)
			fail($sformatf("mismatch at %0t: %0d error pulses in %s, expected %0d", $time,
				pulses, name, exp_pulses));
		$display("test %s: %0d checks, %0d errors", name, checks, errors);
		total_checks += checks;
		total_errors += errors;
		tests++;
		checks = 0;
		errors = 0;
		pulses = 0;
		exp_pulses = 0;
	endtask

endmodule

// File: test/tb_top.sv
module tb_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 16;
	localparam logic [31:0] ERR_BASE  = 32'h0000_1000; // 256 byte SLVERR window
	localparam logic [31:0] HANG_ADDR = 32'h0000_2000;
	localparam int NUM_REQ = 90;
	localparam int LIMIT   = NUM_REQ * (TIMEOUT_CYCLES + 12) + 200;

	logic        clk = 1'b0;
	logic        rst;
	logic        read;
	logic        write;
	logic [31:0] address;
	logic [31:0] wrdata;
	logic [3:0]  byteenable;
	logic [31:0] rddata;
	logic        stall;
	logic        error;
	logic [31:0] awaddr, wdata, araddr, rdata;
	logic [3:0]  wstrb;
	logic [1:0]  bresp, rresp;
	logic        awvalid, awready, wvalid, wready, bvalid, bready;
	logic        arvalid, arready, rvalid, rready;
	logic [31:0] lfsr;
	int          cycles;

	uncached_dbus_top #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_uncached_dbus_top (.*);

	axi_lite_slave_model #(.ERR_BASE(ERR_BASE), .HANG_ADDR(HANG_ADDR)) u_slave (.*);

	dbus_checker #(.ERR_BASE(ERR_BASE), .HANG_ADDR(HANG_ADDR)) u_checker (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic wait_idle();
		while (stall) begin
			@(posedge clk);
			#2;
		end
	endtask

	// Presented while stall is low, so the next edge takes it
	task automatic send(input logic rd, input logic [31:0] a, input logic [31:0] d,
			input logic [3:0] be);
		wait_idle();
		read       = rd;
		write      = !rd;
		address    = a;
		wrdata     = d;
		byteenable = be;
		@(posedge clk);
		#2;
		read  = 1'b0;
		write = 1'b0;
	endtask

	task automatic rand_access(input logic rd);
		logic [31:0] a, d, be;
		take(4, a);
		take(32, d);
		take(4, be);
		send(rd, a << 2, d, be[3:0]);
	endtask

	task automatic finish_test(input string name);
		wait_idle();
		u_checker.end_test(name);
	endtask

	initial begin
		logic [31:0] v, a, d;
		rst = 1'b1;
		cycles = 0;
		lfsr = 32'h3a52;
		read = 1'b0;
		write = 1'b0;
		address = '0;
		wrdata = '0;
		byteenable = '0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		@(posedge clk);
		#2;
		finish_test("reset_state");

		repeat (20) rand_access(1'b0);
		for (int i = 0; i < 16; i++)
			send(1'b1, i * 4, '0, '0);
		finish_test("write_readback");

		repeat (30) begin
			take(1, v);
			rand_access(v[0]);
		end
		finish_test("back_pressure");

		repeat (8) begin
			take(4, a);
			take(32, d);
			send(1'b0, a << 2, d, 4'hf);
			send(1'b1, a << 2, '0, '0); // Goes in while B is still due
		end
		finish_test("overlapped_b");

		send(1'b1, ERR_BASE + 4, '0, '0);
		send(1'b0, ERR_BASE + 8, 32'h1234_5678, 4'hf);
		send(1'b1, ERR_BASE + 8, '0, '0);
		send(1'b0, ERR_BASE + 32'h10, 32'h0bad_cafe, 4'h3);
		finish_test("slave_errors");

		send(1'b1, HANG_ADDR, '0, '0);
		send(1'b0, HANG_ADDR, 32'h5555_aaaa, 4'hf);
		send(1'b0, 32'h24, 32'hc0de_0001, 4'hf);
		send(1'b1, 32'h24, '0, '0);
		finish_test("hang");

		$display("tests %0d, checks %0d, errors %0d", u_checker.tests,
			u_checker.total_checks, u_checker.total_errors);
		if (u_checker.total_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: all.f
verilog/dbus_pkg.sv
verilog/cpu_dbus_if.sv
verilog/bridge_ctl_if.sv
verilog/axi_watchdog.sv
verilog/req_stage.sv
verilog/resp_stage.sv
verilog/uncached_fsm.sv
verilog/uncached_dbus_top.sv
test/axi_lite_slave_model.sv
test/dbus_checker.sv
test/tb_top.sv
